/* design/soc_xbar_pkg.sv */
`default_nettype none

package soc_xbar_pkg;

    //////////////////////////////////////////////////
    // Widths and bank geometry
    //////////////////////////////////////////////////
    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int BE_WIDTH       = 4;
    localparam int NR_INTLV_BANKS = 4;
    localparam int NR_PRIV_BANKS  = 2;
    localparam int NR_BANKS       = NR_INTLV_BANKS + NR_PRIV_BANKS;
    localparam int BANK_WORDS     = 256;
    localparam int ROW_WIDTH      = $clog2(BANK_WORDS);
    localparam int BANK_SEL_WIDTH = 3;

    // Private banks sit after the interleaved ones
    localparam logic [BANK_SEL_WIDTH-1:0] PRIV0_BANK = 3'd4;
    localparam logic [BANK_SEL_WIDTH-1:0] PRIV1_BANK = 3'd5;

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////
    // Legacy alias, top 12 bits 0x000 become 0x1C0
    localparam logic [11:0] ALIAS_PREFIX = 12'h1C0;
    localparam logic [11:0] ALIAS_MATCH  = 12'h000;

    localparam logic [ADDR_WIDTH-1:0] INTLV_START  = 32'h1C01_0000;
    localparam logic [ADDR_WIDTH-1:0] INTLV_END    = 32'h1C01_0FFF;
    localparam logic [ADDR_WIDTH-1:0] PRIV0_START  = 32'h1C00_0000;
    localparam logic [ADDR_WIDTH-1:0] PRIV0_END    = 32'h1C00_03FF;
    localparam logic [ADDR_WIDTH-1:0] PRIV1_START  = 32'h1C00_8000;
    localparam logic [ADDR_WIDTH-1:0] PRIV1_END    = 32'h1C00_83FF;
    localparam logic [ADDR_WIDTH-1:0] PERIPH_START = 32'h1A10_0000;
    localparam logic [ADDR_WIDTH-1:0] PERIPH_END   = 32'h1A1F_FFFF;

    // APB sequencer states
    localparam logic [1:0] APB_IDLE   = 2'd0;
    localparam logic [1:0] APB_SETUP  = 2'd1;
    localparam logic [1:0] APB_ACCESS = 2'd2;

    typedef enum logic [1:0] {
        TGT_INTLV,
        TGT_PRIV,
        TGT_PERIPH,
        TGT_NONE
    } target_e;

    // Same word, seen as word-interleaved or as contiguous rows
    typedef union packed {
        struct packed {
            logic [19:0] tag;
            logic [7:0]  row;
            logic [1:0]  bank;
            logic [1:0]  byte_sel;
        } intlv;
        struct packed {
            logic [21:0] tag;
            logic [7:0]  row;
            logic [1:0]  byte_sel;
        } contig;
    } l2_addr_u;

endpackage

`default_nettype wire

/* design/xbar_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Routed request between decode and dispatch
interface routed_if;
    import soc_xbar_pkg::*;

    logic                  valid;
    logic                  ready;
    target_e               target;
    l2_addr_u              addr;
    logic                  write;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;

    modport src (output valid, target, addr, write, wdata, be, input ready);
    modport dst (input valid, target, addr, write, wdata, be, output ready);
endinterface

// Single-port access into the bank array
interface mem_if;
    import soc_xbar_pkg::*;

    logic                      en;
    logic                      write;
    logic [BANK_SEL_WIDTH-1:0] bank_sel;
    logic [ROW_WIDTH-1:0]      row;
    logic [DATA_WIDTH-1:0]     wdata;
    logic [BE_WIDTH-1:0]       be;
    // Valid one cycle after a read
    logic [DATA_WIDTH-1:0]     rdata;

    modport ctrl (output en, write, bank_sel, row, wdata, be, input rdata);
    modport mem (input en, write, bank_sel, row, wdata, be, output rdata);
endinterface

// Start/done handshake toward the APB sequencer
interface periph_if;
    import soc_xbar_pkg::*;

    logic                  start;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  write;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  done;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;

    modport ctrl (output start, addr, write, wdata, input done, rdata, err);
    modport port (input start, addr, write, wdata, output done, rdata, err);
endinterface

`default_nettype wire

/* design/addr_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decode_stage (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    input  logic [soc_xbar_pkg::ADDR_WIDTH-1:0] req_addr_i,
    input  logic                                req_write_i,
    input  logic [soc_xbar_pkg::DATA_WIDTH-1:0] req_wdata_i,
    input  logic [soc_xbar_pkg::BE_WIDTH-1:0]   req_be_i,
    routed_if.src                               out
);
    import soc_xbar_pkg::*;

    logic [ADDR_WIDTH-1:0] addr_remap;
    target_e               target_d;

    logic                  valid_q;
    target_e               target_q;
    l2_addr_u              addr_q;
    logic                  write_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [BE_WIDTH-1:0]   be_q;

    //////////////////////////////////////////////////
    // Alias remap and rule match
    //////////////////////////////////////////////////
    always_comb begin
        addr_remap = req_addr_i;
        if (req_addr_i[ADDR_WIDTH-1 -: 12] == ALIAS_MATCH) begin
            addr_remap[ADDR_WIDTH-1 -: 12] = ALIAS_PREFIX;
        end
        // Ranges are disjoint, order only sets the default
        target_d = TGT_NONE;
        if (addr_remap >= INTLV_START && addr_remap <= INTLV_END) begin
            target_d = TGT_INTLV;
        end else if ((addr_remap >= PRIV0_START && addr_remap <= PRIV0_END) ||
                     (addr_remap >= PRIV1_START && addr_remap <= PRIV1_END)) begin
            target_d = TGT_PRIV;
        end else if (addr_remap >= PERIPH_START && addr_remap <= PERIPH_END) begin
            target_d = TGT_PERIPH;
        end
    end

    //////////////////////////////////////////////////
    // Register slice
    //////////////////////////////////////////////////
    // Take a new request if empty or the slot drains this cycle
    assign req_ready_o = !valid_q || out.ready;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    // Payload loads only on accept, so it holds while stalled
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            target_q <= target_d;
            addr_q   <= addr_remap;
            write_q  <= req_write_i;
            wdata_q  <= req_wdata_i;
            be_q     <= req_be_i;
        end
    end

    assign out.valid  = valid_q;
    assign out.target = target_q;
    assign out.addr   = addr_q;
    assign out.write  = write_q;
    assign out.wdata  = wdata_q;
    assign out.be     = be_q;

endmodule

`default_nettype wire

/* design/l2_mem_banks.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_banks (
    input logic clk_i,
    mem_if.mem  bus
);
    import soc_xbar_pkg::*;

    // Banks 0-3 interleaved, 4-5 private
    logic [DATA_WIDTH-1:0] mem_q [NR_BANKS][BANK_WORDS];

    //////////////////////////////////////////////////
    // Write path with byte enables
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (bus.en && bus.write) begin
            for (int b = 0; b < BE_WIDTH; b++) begin
                if (bus.be[b]) begin
                    mem_q[bus.bank_sel][bus.row][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////
    // Read register keeps its word until the next read
    always_ff @(posedge clk_i) begin
        if (bus.en && !bus.write) begin
            bus.rdata <= mem_q[bus.bank_sel][bus.row];
        end
    end

endmodule

`default_nettype wire

/* design/apb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_master (
    input  logic                                clk_i,
    input  logic                                rst_i,
    periph_if.port                              ctrl,
    output logic                                psel_o,
    output logic                                penable_o,
    output logic [soc_xbar_pkg::ADDR_WIDTH-1:0] paddr_o,
    output logic                                pwrite_o,
    output logic [soc_xbar_pkg::DATA_WIDTH-1:0] pwdata_o,
    input  logic [soc_xbar_pkg::DATA_WIDTH-1:0] prdata_i,
    input  logic                                pready_i,
    input  logic                                pslverr_i
);
    import soc_xbar_pkg::*;

    logic [1:0]            state_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic                  write_q;
    logic [DATA_WIDTH-1:0] wdata_q;

    //////////////////////////////////////////////////
    // Setup / access sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= APB_IDLE;
        end else begin
            case (state_q)
                APB_IDLE:   if (ctrl.start) state_q <= APB_SETUP;
                APB_SETUP:  state_q <= APB_ACCESS;
                // Stretch access until the slave is ready
                APB_ACCESS: if (pready_i) state_q <= APB_IDLE;
                default:    state_q <= APB_IDLE;
            endcase
        end
    end

    // Address and data held for the whole transfer
    always_ff @(posedge clk_i) begin
        if (state_q == APB_IDLE && ctrl.start) begin
            addr_q  <= ctrl.addr;
            write_q <= ctrl.write;
            wdata_q <= ctrl.wdata;
        end
    end

    assign psel_o    = state_q != APB_IDLE;
    assign penable_o = state_q == APB_ACCESS;
    assign paddr_o   = addr_q;
    assign pwrite_o  = write_q;
    assign pwdata_o  = wdata_q;

    // Completion pulse carries the slave's read data and error
    assign ctrl.done  = (state_q == APB_ACCESS) && pready_i;
    assign ctrl.rdata = prdata_i;
    assign ctrl.err   = pslverr_i;

endmodule

`default_nettype wire

/* design/target_dispatch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module target_dispatch_stage (
    input  logic                                clk_i,
    input  logic                                rst_i,
    routed_if.dst                               in,
    output logic                                rsp_valid_o,
    input  logic                                rsp_ready_i,
    output logic [soc_xbar_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                                rsp_err_o,
    output logic                                psel_o,
    output logic                                penable_o,
    output logic [soc_xbar_pkg::ADDR_WIDTH-1:0] paddr_o,
    output logic                                pwrite_o,
    output logic [soc_xbar_pkg::DATA_WIDTH-1:0] pwdata_o,
    input  logic [soc_xbar_pkg::DATA_WIDTH-1:0] prdata_i,
    input  logic                                pready_i,
    input  logic                                pslverr_i
);
    import soc_xbar_pkg::*;

    mem_if    mem_bus ();
    periph_if periph_bus ();

    logic                      apb_busy_q;
    logic                      rsp_valid_q;
    // Response data comes straight from the bank read register
    logic                      rsp_mem_q;
    logic                      rsp_err_q;
    logic [DATA_WIDTH-1:0]     rsp_rdata_q;
    logic                      accept;
    logic                      to_bank;
    logic [BANK_SEL_WIDTH-1:0] priv_bank;

    // Accept when idle and the response slot is empty or draining
    assign in.ready  = !apb_busy_q && (!rsp_valid_q || rsp_ready_i);
    assign accept    = in.valid && in.ready;
    assign to_bank   = (in.target == TGT_INTLV) || (in.target == TGT_PRIV);
    assign priv_bank = (in.addr >= PRIV1_START) ? PRIV1_BANK : PRIV0_BANK;

    //////////////////////////////////////////////////
    // Bank and APB request
    //////////////////////////////////////////////////
    always_comb begin
        mem_bus.en    = accept && to_bank;
        mem_bus.write = in.write;
        mem_bus.wdata = in.wdata;
        mem_bus.be    = in.be;
        if (in.target == TGT_INTLV) begin
            mem_bus.bank_sel = BANK_SEL_WIDTH'(in.addr.intlv.bank);
            mem_bus.row      = in.addr.intlv.row;
        end else begin
            mem_bus.bank_sel = priv_bank;
            mem_bus.row      = in.addr.contig.row;
        end
    end

    assign periph_bus.start = accept && (in.target == TGT_PERIPH);
    assign periph_bus.addr  = in.addr;
    assign periph_bus.write = in.write;
    assign periph_bus.wdata = in.wdata;

    //////////////////////////////////////////////////
    // Response slot
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            apb_busy_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
            rsp_mem_q   <= 1'b0;
        end else if (accept) begin
            apb_busy_q  <= in.target == TGT_PERIPH;
            rsp_valid_q <= in.target != TGT_PERIPH;
            rsp_mem_q   <= to_bank && !in.write;
        end else if (periph_bus.done) begin
            apb_busy_q  <= 1'b0;
            rsp_valid_q <= 1'b1;
            rsp_mem_q   <= 1'b0;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Writes and unmapped return zero, only unmapped flags an error
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_rdata_q <= '0;
            rsp_err_q   <= in.target == TGT_NONE;
        end else if (periph_bus.done) begin
            rsp_rdata_q <= periph_bus.rdata;
            rsp_err_q   <= periph_bus.err;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_mem_q ? mem_bus.rdata : rsp_rdata_q;
    assign rsp_err_o   = rsp_err_q;

    l2_mem_banks i_l2_mem_banks (
        .clk_i,
        .bus (mem_bus.mem)
    );

    apb_master i_apb_master (
        .clk_i,
        .rst_i,
        .ctrl (periph_bus.port),
        .psel_o,
        .penable_o,
        .paddr_o,
        .pwrite_o,
        .pwdata_o,
        .prdata_i,
        .pready_i,
        .pslverr_i
    );

endmodule

`default_nettype wire

/* design/soc_xbar_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_xbar_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // Request channel from the data master
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    input  logic [soc_xbar_pkg::ADDR_WIDTH-1:0] req_addr_i,
    input  logic                                req_write_i,
    input  logic [soc_xbar_pkg::DATA_WIDTH-1:0] req_wdata_i,
    input  logic [soc_xbar_pkg::BE_WIDTH-1:0]   req_be_i,
    // In-order response channel
    output logic                                rsp_valid_o,
    input  logic                                rsp_ready_i,
    output logic [soc_xbar_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                                rsp_err_o,
    // APB peripheral bus
    output logic                                psel_o,
    output logic                                penable_o,
    output logic [soc_xbar_pkg::ADDR_WIDTH-1:0] paddr_o,
    output logic                                pwrite_o,
    output logic [soc_xbar_pkg::DATA_WIDTH-1:0] pwdata_o,
    input  logic [soc_xbar_pkg::DATA_WIDTH-1:0] prdata_i,
    input  logic                                pready_i,
    input  logic                                pslverr_i
);
    import soc_xbar_pkg::*;

    //////////////////////////////////////////////////
    // Decode then dispatch
    //////////////////////////////////////////////////
    routed_if routed ();

    addr_decode_stage i_addr_decode_stage (
        .clk_i,
        .rst_i,
        .req_valid_i,
        .req_ready_o,
        .req_addr_i,
        .req_write_i,
        .req_wdata_i,
        .req_be_i,
        .out         (routed.src)
    );

    target_dispatch_stage i_target_dispatch_stage (
        .clk_i,
        .rst_i,
        .in          (routed.dst),
        .rsp_valid_o,
        .rsp_ready_i,
        .rsp_rdata_o,
        .rsp_err_o,
        .psel_o,
        .penable_o,
        .paddr_o,
        .pwrite_o,
        .pwdata_o,
        .prdata_i,
        .pready_i,
        .pslverr_i
    );

endmodule

`default_nettype wire

/* test/xbar_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module xbar_properties (
    input logic                                clk_i,
    input logic                                rst_i,
    input logic                                rsp_valid_o,
    input logic                                rsp_ready_i,
    input logic [soc_xbar_pkg::DATA_WIDTH-1:0] rsp_rdata_o,
    input logic                                rsp_err_o,
    input logic                                psel_o,
    input logic                                penable_o,
    input logic [soc_xbar_pkg::ADDR_WIDTH-1:0] paddr_o,
    input logic                                pready_i
);
    import soc_xbar_pkg::*;

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    //////////////////////////////////////////////////
    // Response channel
    //////////////////////////////////////////////////
    // Stalled response keeps valid and payload
    rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (rsp_valid_o && !rsp_ready_i) |=>
        (rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o)))
        else begin
            $error("response changed while stalled");
            fail_count++;
        end

    //////////////////////////////////////////////////
    // APB bus
    //////////////////////////////////////////////////
    penable_needs_psel: assert property (@(posedge clk_i) penable_o |-> psel_o)
        else begin
            $error("penable_o high without psel_o");
            fail_count++;
        end

    // Address frozen from setup until the access completes
    paddr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (psel_o && !(penable_o && pready_i)) |=> (psel_o && $stable(paddr_o)))
        else begin
            $error("paddr_o changed during a transfer");
            fail_count++;
        end

    psel_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !psel_o)
        else begin
            $error("psel_o high after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

/* test/tb_soc_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_xbar;
    import soc_xbar_pkg::*;

    localparam int NUM_REQ    = 400;
    localparam int WAIT_LIMIT = 200;

    logic                  clk_i;
    logic                  rst_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    logic [ADDR_WIDTH-1:0] req_addr_i;
    logic                  req_write_i;
    logic [DATA_WIDTH-1:0] req_wdata_i;
    logic [BE_WIDTH-1:0]   req_be_i;
    logic                  rsp_valid_o;
    logic                  rsp_ready_i;
    logic [DATA_WIDTH-1:0] rsp_rdata_o;
    logic                  rsp_err_o;
    logic                  psel_o;
    logic                  penable_o;
    logic [ADDR_WIDTH-1:0] paddr_o;
    logic                  pwrite_o;
    logic [DATA_WIDTH-1:0] pwdata_o;
    logic [DATA_WIDTH-1:0] prdata_i;
    logic                  pready_i;
    logic                  pslverr_i;

    integer seed = 16;
    int     mismatch_count = 0;
    int     failure_count = 0;
    int     rsp_count = 0;
    bit     timed_out = 1'b0;

    // Reference model state, byte-valid memory keyed by word address
    logic [31:0] ref_mem   [logic [31:0]];
    logic [3:0]  ref_valid [logic [31:0]];
    logic [31:0] ref_regs  [256];
    logic [31:0] apb_regs  [256];
    logic [31:0] exp_rdata_q [$];
    logic [31:0] exp_mask_q  [$];
    logic        exp_err_q   [$];
    logic [31:0] apb_addr_q  [$];
    logic        apb_write_q [$];
    logic [31:0] apb_wdata_q [$];

    soc_xbar_top dut0 (.*);

    bind soc_xbar_top xbar_properties props0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .psel_o      (psel_o),
        .penable_o   (penable_o),
        .paddr_o     (paddr_o),
        .pready_i    (pready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Map rules and reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] fill_word(input int i);
        return 32'hC0DE_0000 ^ (32'(i) * 32'h0001_0101);
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    // Legacy alias, zero prefix moves into the L2 window
    function automatic logic [31:0] remap_alias(input logic [31:0] a);
        logic [31:0] m;
        m = a;
        if (a[31:20] == ALIAS_MATCH) begin
            m[31:20] = ALIAS_PREFIX;
        end
        return m;
    endfunction

    function automatic target_e classify_target(input logic [31:0] a);
        if (a >= INTLV_START && a <= INTLV_END) return TGT_INTLV;
        if (a >= PRIV0_START && a <= PRIV0_END) return TGT_PRIV;
        if (a >= PRIV1_START && a <= PRIV1_END) return TGT_PRIV;
        if (a >= PERIPH_START && a <= PERIPH_END) return TGT_PERIPH;
        return TGT_NONE;
    endfunction

    // Small windows so reads often hit earlier writes
    function automatic logic [31:0] pick_address();
        logic [31:0] r;
        logic [31:0] a;
        r = $random(seed);
        case (r[2:0])
            3'd0, 3'd1: a = INTLV_START + {24'd0, r[9:4], 2'b00};
            3'd2:       a = PRIV0_START + {26'd0, r[7:4], 2'b00};
            3'd3:       a = PRIV1_START + {26'd0, r[7:4], 2'b00};
            3'd4, 3'd5: a = PERIPH_START + {20'd0, r[13:4], 2'b00};
            default:    a = (r[30] ? 32'h3000_0000 : 32'h1C02_0000) + {16'd0, r[19:6], 2'b00};
        endcase
        if (r[31] && a[31:20] == ALIAS_PREFIX) begin
            a[31:20] = ALIAS_MATCH;
        end
        return a;
    endfunction

    task automatic push_expected(input logic [31:0] rdata, input logic [31:0] mask,
                                 input logic err);
        exp_rdata_q.push_back(rdata);
        exp_mask_q.push_back(mask);
        exp_err_q.push_back(err);
    endtask

    task automatic model_request(input logic [31:0] addr, input logic write,
                                 input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] a;
        logic [31:0] key;
        logic [31:0] old;
        logic [3:0]  valid;
        target_e     tgt;
        a     = remap_alias(addr);
        tgt   = classify_target(a);
        key   = {2'b00, a[31:2]};
        old   = ref_mem.exists(key) ? ref_mem[key] : 32'h0;
        valid = ref_valid.exists(key) ? ref_valid[key] : 4'h0;
        case (tgt)
            TGT_INTLV, TGT_PRIV: begin
                if (write) begin
                    ref_mem[key]   = (old & ~byte_mask(be)) | (wdata & byte_mask(be));
                    ref_valid[key] = valid | be;
                    push_expected(32'h0, 32'hFFFF_FFFF, 1'b0);
                end else begin
                    // Only bytes written earlier are compared
                    push_expected(old, byte_mask(valid), 1'b0);
                end
            end
            TGT_PERIPH: begin
                apb_addr_q.push_back(a);
                apb_write_q.push_back(write);
                apb_wdata_q.push_back(wdata);
                if (a[11]) begin
                    push_expected(32'h0, 32'hFFFF_FFFF, 1'b1);
                end else if (write) begin
                    ref_regs[a[9:2]] = wdata;
                    push_expected(32'h0, 32'hFFFF_FFFF, 1'b0);
                end else begin
                    push_expected(ref_regs[a[9:2]], 32'hFFFF_FFFF, 1'b0);
                end
            end
            default: push_expected(32'h0, 32'hFFFF_FFFF, 1'b1);
        endcase
    endtask

    //////////////////////////////////////////////////
    // Handshake waits and response check
    //////////////////////////////////////////////////
    // Sampled just after the falling edge, stable until the next rising edge
    task automatic wait_accept(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && !timed_out && cycles < WAIT_LIMIT) begin
            #1;
            if (req_ready_o) begin
                ok = 1'b1;
            end else begin
                @(negedge clk_i);
                cycles++;
            end
        end
    endtask

    task automatic wait_response(output bit got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && !timed_out && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            #1;
            got = rsp_valid_o && rsp_ready_i;
            cycles++;
        end
    endtask

    task automatic check_response();
        logic [31:0] exp_rdata;
        logic [31:0] mask;
        logic        exp_err;
        rsp_count++;
        assert (exp_rdata_q.size() != 0) else begin
            failure_count++;
            $display("response arrived with no request outstanding");
        end
        if (exp_rdata_q.size() != 0) begin
            exp_rdata = exp_rdata_q.pop_front();
            mask      = exp_mask_q.pop_front();
            exp_err   = exp_err_q.pop_front();
            assert ((rsp_rdata_o & mask) == (exp_rdata & mask)) else begin
                mismatch_count++;
                $display("mismatch at %0t: rsp_rdata_o got %h expected %h (byte mask %h)",
                         $time, rsp_rdata_o, exp_rdata, mask);
            end
            assert (rsp_err_o == exp_err) else begin
                mismatch_count++;
                $display("mismatch at %0t: rsp_err_o got %b expected %b",
                         $time, rsp_err_o, exp_err);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Request stimulus
    //////////////////////////////////////////////////
    initial begin : stimulus
        logic [31:0] rnd;
        bit          ok;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_write_i = 1'b0;
        req_wdata_i = '0;
        req_be_i    = '0;
        for (int i = 0; i < 256; i++) begin
            ref_regs[i] = fill_word(i);
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        for (int n = 0; n < NUM_REQ && !timed_out; n++) begin
            @(negedge clk_i);
            rnd = $random(seed);
            // Occasional idle cycle between requests
            if (rnd[2:0] == 3'd0) begin
                req_valid_i = 1'b0;
                @(negedge clk_i);
            end
            req_valid_i = 1'b1;
            req_addr_i  = pick_address();
            req_write_i = rnd[8];
            req_wdata_i = $random(seed);
            req_be_i    = rnd[15:12];
            wait_accept(ok);
            assert (ok || timed_out) else begin
                failure_count++;
                timed_out = 1'b1;
                $display("timeout waiting for req_ready_o at %0t", $time);
            end
            if (ok) begin
                model_request(req_addr_i, req_write_i, req_wdata_i, req_be_i);
            end
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
    end

    // Random back-pressure on the response channel
    initial begin : response_stall
        rsp_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            rsp_ready_i = (($random(seed) & 3) != 0);
        end
    end

    //////////////////////////////////////////////////
    // APB peripheral model
    //////////////////////////////////////////////////
    initial begin : apb_peripheral
        int          wait_left;
        logic [31:0] exp_paddr;
        logic        exp_pwrite;
        logic [31:0] exp_pwdata;
        wait_left = 0;
        pready_i  = 1'b0;
        prdata_i  = '0;
        pslverr_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            apb_regs[i] = fill_word(i);
        end
        forever begin
            @(negedge clk_i);
            pready_i  = 1'b0;
            prdata_i  = '0;
            pslverr_i = 1'b0;
            if (psel_o && !penable_o) begin
                // Setup phase, 0 to 3 wait cycles in access
                wait_left = $random(seed) & 3;
                assert (apb_addr_q.size() != 0) else begin
                    failure_count++;
                    $display("APB transfer started without a peripheral request");
                end
                if (apb_addr_q.size() != 0) begin
                    exp_paddr  = apb_addr_q.pop_front();
                    exp_pwrite = apb_write_q.pop_front();
                    exp_pwdata = apb_wdata_q.pop_front();
                    assert (paddr_o == exp_paddr) else begin
                        mismatch_count++;
                        $display("mismatch at %0t: paddr_o got %h expected %h",
                                 $time, paddr_o, exp_paddr);
                    end
                    assert (pwrite_o == exp_pwrite) else begin
                        mismatch_count++;
                        $display("mismatch at %0t: pwrite_o got %b expected %b",
                                 $time, pwrite_o, exp_pwrite);
                    end
                    // Writes carry the whole request word
                    assert (!exp_pwrite || pwdata_o == exp_pwdata) else begin
                        mismatch_count++;
                        $display("mismatch at %0t: pwdata_o got %h expected %h",
                                 $time, pwdata_o, exp_pwdata);
                    end
                end
            end else if (psel_o && penable_o) begin
                if (wait_left == 0) begin
                    pready_i  = 1'b1;
                    pslverr_i = paddr_o[11];
                    if (!paddr_o[11] && pwrite_o) begin
                        apb_regs[paddr_o[9:2]] = pwdata_o;
                    end else if (!paddr_o[11]) begin
                        prdata_i = apb_regs[paddr_o[9:2]];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Response monitor and end of run
    //////////////////////////////////////////////////
    initial begin : monitor
        bit got;
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (rst_i && cycles < 50) begin
            @(negedge clk_i);
            cycles++;
        end
        while (rsp_count < NUM_REQ && !timed_out) begin
            wait_response(got);
            assert (got || timed_out) else begin
                failure_count++;
                timed_out = 1'b1;
                $display("timeout waiting for a response after %0d responses", rsp_count);
            end
            if (got) begin
                check_response();
            end
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, failure_count, dut0.props0.fail_count);
        if (mismatch_count == 0 && failure_count == 0 && dut0.props0.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/soc_xbar_pkg.sv
design/xbar_if.sv
design/addr_decode_stage.sv
design/l2_mem_banks.sv
design/apb_master.sv
design/target_dispatch_stage.sv
design/soc_xbar_top.sv
test/xbar_properties.sv
test/tb_soc_xbar.sv

/* run.sh */
#!/bin/sh
# Build and run the crossbar testbench with Verilator
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_soc_xbar -Mdir obj_dir -f project.f

status=0
obj_dir/Vtb_soc_xbar +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
